/* rdma_flow_pkg.sv */
package rdma_flow_pkg;

    localparam int REGION_BITS = 2;
    localparam int PID_BITS = 4;
    localparam int KEY_BITS = 1 + REGION_BITS + PID_BITS;

    typedef enum logic [1:0] {
        op_rd_req  = 2'd0,
        op_wr_req  = 2'd1,
        op_rd_resp = 2'd2,
        op_wr_ack  = 2'd3
    } opcode_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [REGION_BITS-1:0] region;
        logic [PID_BITS-1:0]    pid;
        logic [15:0]            len;
        logic [7:0]             offs;
    } req_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [REGION_BITS-1:0] region;
        logic [PID_BITS-1:0]    pid;
        logic                   last;
    } ack_t;

    // Table address with read and write traffic kept apart
    typedef struct packed {
        logic                   rd;
        logic [REGION_BITS-1:0] region;
        logic [PID_BITS-1:0]    pid;
    } flow_key_t;

    // Head and tail sized for up to 16 outstanding
    typedef struct packed {
        logic [6:0] spare;
        logic       issued;
        logic [3:0] head;
        logic [3:0] tail;
    } ssn_rec_t;

    function automatic logic is_rd_req(opcode_t op);
        return op == op_rd_req;
    endfunction

    function automatic logic is_rd_resp(opcode_t op);
        return op == op_rd_resp;
    endfunction

endpackage

/* ssn_table.sv */
`timescale 1ns/1ps

module ssn_table
    import rdma_flow_pkg::*;
(
    input  logic      aclk,
    input  logic      we,
    input  flow_key_t addr,
    input  ssn_rec_t  wdata,
    output ssn_rec_t  rdata
);

    localparam int N_KEYS = 2 ** KEY_BITS;

    ssn_rec_t mem [N_KEYS];

    // Zero image in place of a table loader
    initial begin
        for (int i = 0; i < N_KEYS; i++) begin
            mem[i] = '0;
        end
    end

    // Read returns the old record on a same-address write
    always @(posedge aclk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* meta_queue.sv */
`timescale 1ns/1ps

module meta_queue #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [7:0]
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic s_valid,
    output logic s_ready,
    input  T     s_data,
    output logic m_valid,
    input  logic m_ready,
    output T     m_data
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign s_ready = (count != CNT_BITS'(DEPTH));
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge aclk) disable iff (!aresetn)
        count <= CNT_BITS'(DEPTH));

endmodule

/* flow_ctrl.sv */
`timescale 1ns/1ps

module flow_ctrl
    import rdma_flow_pkg::*;
#(
    parameter int N_OST = 4
) (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      s_req_valid,
    output logic      s_req_ready,
    input  req_t      s_req,
    input  logic      s_ack_valid,
    output logic      s_ack_ready,
    input  ack_t      s_ack,
    output logic      tbl_we,
    output flow_key_t tbl_addr,
    output ssn_rec_t  tbl_wdata,
    input  ssn_rec_t  tbl_rdata,
    output logic      rq_valid,
    input  logic      rq_ready,
    output req_t      rq_data,
    output logic      aq_valid,
    input  logic      aq_ready,
    output ack_t      aq_data
);

    localparam int OST_BITS = $clog2(N_OST);

    typedef enum logic [2:0] {
        st_idle,
        st_ack_lup_wait,
        st_req_lup_wait,
        st_ack_lup,
        st_req_lup
    } state_t;

    state_t    state;
    state_t    state_nxt;
    flow_key_t key_q;
    flow_key_t key_nxt;
    flow_key_t ack_key;
    flow_key_t req_key;

    logic [OST_BITS-1:0] head;
    logic [OST_BITS-1:0] tail;
    logic [OST_BITS-1:0] head_nxt;
    logic [OST_BITS-1:0] tail_nxt;
    logic                issued;
    logic                issued_nxt;
    logic                slot_free;
    logic                req_match;

    assign ack_key = flow_key_t'{rd: is_rd_resp(s_ack.opcode),
                                 region: s_ack.region, pid: s_ack.pid};
    assign req_key = flow_key_t'{rd: is_rd_req(s_req.opcode),
                                 region: s_req.region, pid: s_req.pid};

    assign head   = tbl_rdata.head[OST_BITS-1:0];
    assign tail   = tbl_rdata.tail[OST_BITS-1:0];
    assign issued = tbl_rdata.issued;

    // Equal pointers mean empty unless issued is set
    assign slot_free = !issued || (head != tail);
    // Source may have withdrawn a blocked request during the lookup
    assign req_match = s_req_valid && (req_key == key_q);

    assign tbl_wdata = ssn_rec_t'{spare: '0, issued: issued_nxt,
                                  head: 4'(head_nxt), tail: 4'(tail_nxt)};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        key_q <= key_nxt;
    end

    // Acks win over requests
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (s_ack_valid) begin
                    state_nxt = st_ack_lup_wait;
                end else if (s_req_valid && rq_ready) begin
                    state_nxt = st_req_lup_wait;
                end
            end
            st_ack_lup_wait: state_nxt = st_ack_lup;
            st_req_lup_wait: state_nxt = st_req_lup;
            default:         state_nxt = st_idle;
        endcase
    end

    always_comb begin
        key_nxt      = key_q;
        s_ack_ready  = 1'b0;
        aq_valid     = 1'b0;
        aq_data      = s_ack;
        s_req_ready  = 1'b0;
        rq_valid     = 1'b0;
        rq_data      = s_req;
        rq_data.offs = 8'(head);
        tbl_we       = 1'b0;
        tbl_addr     = key_q;
        head_nxt     = head;
        tail_nxt     = tail;
        issued_nxt   = issued;

        case (state)
            st_idle: begin
                if (s_ack_valid) begin
                    s_ack_ready = 1'b1;
                    aq_valid    = s_ack.last;
                    tbl_addr    = ack_key;
                    key_nxt     = ack_key;
                end else if (s_req_valid && rq_ready) begin
                    tbl_addr = req_key;
                    key_nxt  = req_key;
                end
            end
            st_ack_lup: begin
                tail_nxt   = tail + 1'b1;
                issued_nxt = (head == tail_nxt) ? 1'b0 : issued;
                tbl_we     = 1'b1;
            end
            st_req_lup: begin
                // Full key falls back to idle and retries
                if (req_match && slot_free) begin
                    s_req_ready = 1'b1;
                    rq_valid    = 1'b1;
                    head_nxt    = head + 1'b1;
                    issued_nxt  = 1'b1;
                    tbl_we      = 1'b1;
                end
            end
            default: ;
        endcase
    end

    a_aq_room: assert property (@(posedge aclk) disable iff (!aresetn)
        aq_valid |-> aq_ready);

    // An admitted request must find room in the request queue
    a_req_ready_lup: assert property (@(posedge aclk) disable iff (!aresetn)
        s_req_ready |-> (state == st_req_lup) && rq_ready);

endmodule

/* rdma_flow_top.sv */
`timescale 1ns/1ps

module rdma_flow_top
    import rdma_flow_pkg::*;
#(
    parameter int N_OST = 4
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic s_req_valid,
    output logic s_req_ready,
    input  req_t s_req,
    input  logic s_ack_valid,
    output logic s_ack_ready,
    input  ack_t s_ack,
    output logic m_req_valid,
    input  logic m_req_ready,
    output req_t m_req,
    output logic m_ack_valid,
    input  logic m_ack_ready,
    output ack_t m_ack
);

    logic      tbl_we;
    flow_key_t tbl_addr;
    ssn_rec_t  tbl_wdata;
    ssn_rec_t  tbl_rdata;

    logic rq_valid;
    logic rq_ready;
    req_t rq_data;
    logic aq_valid;
    logic aq_ready;
    ack_t aq_data;

    flow_ctrl #(
        .N_OST(N_OST)
    ) ctrl0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_req_valid(s_req_valid),
        .s_req_ready(s_req_ready),
        .s_req      (s_req),
        .s_ack_valid(s_ack_valid),
        .s_ack_ready(s_ack_ready),
        .s_ack      (s_ack),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_wdata  (tbl_wdata),
        .tbl_rdata  (tbl_rdata),
        .rq_valid   (rq_valid),
        .rq_ready   (rq_ready),
        .rq_data    (rq_data),
        .aq_valid   (aq_valid),
        .aq_ready   (aq_ready),
        .aq_data    (aq_data)
    );

    // Per-key head, tail and issued records
    ssn_table tbl0 (
        .aclk (aclk),
        .we   (tbl_we),
        .addr (tbl_addr),
        .wdata(tbl_wdata),
        .rdata(tbl_rdata)
    );

    // Admitted requests
    meta_queue #(
        .DEPTH(N_OST),
        .T    (req_t)
    ) sq0 (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_valid(rq_valid),
        .s_ready(rq_ready),
        .s_data (rq_data),
        .m_valid(m_req_valid),
        .m_ready(m_req_ready),
        .m_data (m_req)
    );

    // Last acks only
    meta_queue #(
        .DEPTH(N_OST),
        .T    (ack_t)
    ) cq0 (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_valid(aq_valid),
        .s_ready(aq_ready),
        .s_data (aq_data),
        .m_valid(m_ack_valid),
        .m_ready(m_ack_ready),
        .m_data (m_ack)
    );

endmodule

/* tb_rdma_flow.sv */
`timescale 1ns/1ps

module tb_rdma_flow
    import rdma_flow_pkg::*;
();

    localparam int N_OST    = 4;
    localparam int PERIOD   = 40;
    localparam int MAX_RECS = 64;
    localparam int N_KEYS   = 128;

    logic aclk;
    logic aresetn;
    logic s_req_valid;
    logic s_req_ready;
    req_t s_req;
    logic s_ack_valid;
    logic s_ack_ready;
    ack_t s_ack;
    logic m_req_valid;
    logic m_req_ready;
    req_t m_req;
    logic m_ack_valid;
    logic m_ack_ready;
    ack_t m_ack;

    logic [43:0] recs [MAX_RECS];
    int          n_recs;
    int          errors;
    int          cycles;
    int          limit;
    int          in_queue;
    int          ack_hold;
    int          req_hold;
    logic [31:0] rng;

    // Reference copy of the pointer records
    int model_head [N_KEYS];
    int model_tail [N_KEYS];
    bit model_issued [N_KEYS];

    req_t exp_req [$];
    ack_t exp_ack [$];

    rdma_flow_top #(
        .N_OST(N_OST)
    ) dut0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_req_valid(s_req_valid),
        .s_req_ready(s_req_ready),
        .s_req      (s_req),
        .s_ack_valid(s_ack_valid),
        .s_ack_ready(s_ack_ready),
        .s_ack      (s_ack),
        .m_req_valid(m_req_valid),
        .m_req_ready(m_req_ready),
        .m_req      (m_req),
        .m_ack_valid(m_ack_valid),
        .m_ack_ready(m_ack_ready),
        .m_ack      (m_ack)
    );

    initial begin
        aclk = 1'b0;
        forever #(PERIOD/2) aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Entered and left on a falling edge
    task automatic send_req(input logic [43:0] r);
        int   key;
        int   offs;
        logic blocked;
        req_t want;
        key     = int'({r[39:36] == 4'd0, r[33:32], r[31:28]});
        blocked = model_issued[key] && (model_head[key] == model_tail[key]);
        offs    = model_head[key];
        check("blocked flag", 32'(r[3:0] != 4'd0), 32'(blocked));
        if (!blocked) begin
            check("model offs", 32'(r[7:4]), 32'(offs));
        end
        s_req_valid = 1'b1;
        // Junk offs for the DUT to overwrite
        s_req = req_t'{opcode: opcode_t'(r[37:36]), region: r[33:32], pid: r[31:28],
                       len: r[27:12], offs: 8'hee};
        if (blocked) begin
            repeat (12) begin
                #(PERIOD/4);
                check("s_req_ready", 32'd0, 32'(s_req_ready));
                @(negedge aclk);
            end
        end else begin
            #(PERIOD/4);
            while (!s_req_ready) begin
                @(negedge aclk);
                #(PERIOD/4);
            end
            want      = s_req;
            want.offs = 8'(offs);
            exp_req.push_back(want);
            in_queue++;
            model_head[key]   = (offs + 1) % N_OST;
            model_issued[key] = 1'b1;
            @(negedge aclk);
        end
        s_req_valid = 1'b0;
    endtask

    task automatic send_ack(input logic [43:0] r);
        int key;
        key         = int'({r[39:36] == 4'd2, r[33:32], r[31:28]});
        s_ack_valid = 1'b1;
        s_ack = ack_t'{opcode: opcode_t'(r[37:36]), region: r[33:32], pid: r[31:28],
                       last: r[8]};
        #(PERIOD/4);
        while (!s_ack_ready) begin
            @(negedge aclk);
            #(PERIOD/4);
        end
        if (s_ack.last) begin
            exp_ack.push_back(s_ack);
        end
        model_tail[key] = (model_tail[key] + 1) % N_OST;
        if (model_tail[key] == model_head[key]) begin
            model_issued[key] = 1'b0;
        end
        @(negedge aclk);
        s_ack_valid = 1'b0;
    endtask

    initial begin
        aresetn     = 1'b0;
        s_req_valid = 1'b0;
        s_req       = '0;
        s_ack_valid = 1'b0;
        s_ack       = '0;
        errors      = 0;
        in_queue    = 0;
        for (int k = 0; k < N_KEYS; k++) begin
            model_head[k]   = 0;
            model_tail[k]   = 0;
            model_issued[k] = 1'b0;
        end
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '1;
        end
        $readmemh("flow_tests.mem", recs);
        n_recs = 0;
        while (n_recs < MAX_RECS && recs[n_recs][43:40] != 4'hf) begin
            n_recs++;
        end
        limit = 40 * n_recs + 200;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        for (int i = 0; i < n_recs; i++) begin
            if (recs[i][43:40] == 4'd1) begin
                send_ack(recs[i]);
            end else begin
                send_req(recs[i]);
            end
        end
        while (exp_req.size() != 0 || exp_ack.size() != 0) begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Output side with random back-pressure
    initial begin
        ack_t want_ack;
        m_req_ready = 1'b0;
        m_ack_ready = 1'b0;
        ack_hold    = 0;
        req_hold    = 0;
        rng         = 32'h83bd;
        @(posedge aresetn);
        forever begin
            @(negedge aclk);
            check("queued requests over N_OST", 32'd0, 32'(in_queue > N_OST));
            rng = xorshift32(rng);
            // Long request stalls let the queue fill up
            if (req_hold > 0) begin
                req_hold--;
                m_req_ready = 1'b0;
            end else if (rng[12:10] == 3'd0) begin
                req_hold    = 16 + int'(rng[15:13]);
                m_req_ready = 1'b0;
            end else begin
                m_req_ready = (rng[2:0] > 3'd2);
            end
            // Ack stalls stay shorter than the queue
            if (ack_hold > 0) begin
                ack_hold--;
                m_ack_ready = 1'b0;
            end else if (rng[7:5] == 3'd0) begin
                ack_hold    = int'(rng[9:8]) % 3;
                m_ack_ready = 1'b0;
            end else begin
                m_ack_ready = 1'b1;
            end
            #(PERIOD/4);
            if (m_req_valid && m_req_ready) begin
                if (exp_req.size() == 0) begin
                    errors++;
                    $display("Unexpected request on m_req at %0t ns", $time);
                end else begin
                    check("m_req", exp_req.pop_front(), m_req);
                    in_queue--;
                end
            end
            if (m_ack_valid && m_ack_ready) begin
                if (exp_ack.size() == 0) begin
                    errors++;
                    $display("Unexpected acknowledgement on m_ack at %0t ns", $time);
                end else begin
                    want_ack = exp_ack.pop_front();
                    check("m_ack", {23'd0, want_ack}, {23'd0, m_ack});
                end
            end
        end
    end

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("Errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* flow_tests.mem */
// Hex digits: kind(0 req, 1 ack) opcode region pid len(4) last offs blocked
// offs is the expected slot of an admitted request
00130040000
00130041010
00130042020
00130043030
00130044001
// Interleaved keys restart at slot 0
01130100000
00150200000
01130101010
00150201010
00230300000
// Acks free slots, the head wraps
12130000000
00130045000
00130046001
12130000100
13130000100
00130047010
12130000000
12150000100
00150202020
// Burst on one write key
01200400000
01200401010
01200402020
01200403030
01200404001
13200000100
13200000100
01200405000
01200406010
01200407001
13200000000
13200000100
13200000100
13200000000
01200408020

/* tb.f */
rdma_flow_pkg.sv
ssn_table.sv
meta_queue.sv
flow_ctrl.sv
rdma_flow_top.sv
tb_rdma_flow.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rdma_flow
FILELIST = tb.f
BUILD    = obj_dir

SRCS = $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD)
